// File: cache_params.svh
// size macros for the L1 data cache, include wherever cache widths or depths are needed
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// data and address widths
`define L1_WORD_W       32
`define L1_ADDR_W       32

// geometry
`define L1_BLOCK_WORDS  2    // words per block
`define L1_N_SETS       16   // direct mapped, one frame per set

// log2 of the geometry above, kept in step by hand
`define L1_BLOCK_BITS   1
`define L1_SET_BITS     4

// what is left of the address after set, word and byte bits
`define L1_TAG_BITS     (`L1_ADDR_W - `L1_SET_BITS - `L1_BLOCK_BITS - 2)

`endif

// File: cache_pkg.sv
// shared types of the L1 data cache, imported by every cache module and the testbench
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    typedef logic [`L1_WORD_W-1:0] word_t;
    typedef word_t [`L1_BLOCK_WORDS-1:0] block_t;

    // request address split into its cache fields
    typedef struct packed {
        logic [`L1_TAG_BITS-1:0]   tag_bits;
        logic [`L1_SET_BITS-1:0]   set_idx;
        logic [`L1_BLOCK_BITS-1:0] word_idx;
        logic [1:0]                byte_idx;
    } cache_addr_t;

    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [`L1_TAG_BITS-1:0] tag_bits;
    } cache_tag_t;

    typedef struct packed {
        cache_tag_t tag;
        block_t     data;
    } cache_frame_t;

    // processor side
    typedef struct packed {
        logic                  ren;
        logic                  wen;
        logic [`L1_ADDR_W-1:0] addr;
        word_t                 wdata;
        logic [3:0]            byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } cpu_rsp_t;

    // memory side, one block per transfer
    typedef struct packed {
        logic                  ren;
        logic                  wen;
        logic [`L1_ADDR_W-1:0] addr;   // block aligned
        block_t                wdata;
    } mem_req_t;

    typedef struct packed {
        logic   busy;
        block_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        CLEAR,
        READY,
        WRITEBACK,
        FETCH,
        FLUSH
    } cache_state_t;

endpackage

`default_nettype wire

// File: cache_frame_ram.sv
// frame storage of the cache, one frame per set, read combinationally and written under a mask
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_frame_ram (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic [`L1_SET_BITS-1:0] sel,
    input  logic                    wen,
    input  cache_pkg::cache_frame_t wval,
    input  cache_pkg::cache_frame_t wmask,
    output cache_pkg::cache_frame_t rval
);
    import cache_pkg::*;

    cache_frame_t frames [`L1_N_SETS];

    assign rval = frames[sel];

    // a mask bit of zero lets the new value through
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `L1_N_SETS; i++) begin
                frames[i] <= '0;
            end
        end else if (wen) begin
            frames[sel] <= (frames[sel] & wmask) | (wval & ~wmask);
        end
    end

endmodule

`default_nettype wire

// File: cache_lookup.sv
// tag compare, word select and byte merging for the cache, feeds the controller
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_lookup (
    input  cache_pkg::cache_state_t state,
    input  cache_pkg::cpu_req_t     req,
    input  logic [`L1_SET_BITS-1:0] sel,
    input  cache_pkg::cache_frame_t frame,
    input  cache_pkg::block_t       fill,
    output logic                    hit,
    output logic                    victim_dirty,
    output cache_pkg::word_t        rdata,
    output cache_pkg::cache_frame_t hit_frame,
    output cache_pkg::cache_frame_t fill_frame,
    output logic [`L1_ADDR_W-1:0]   victim_addr
);
    import cache_pkg::*;

    cache_addr_t addr;
    logic        tag_match;

    // replace the enabled byte lanes of a word
    function automatic word_t merge_word(input word_t old_w, input word_t new_w,
                                         input logic [3:0] be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign addr      = cache_addr_t'(req.addr);
    assign tag_match = frame.tag.valid && (frame.tag.tag_bits == addr.tag_bits);
    assign hit       = (state == READY) && (req.ren || req.wen) && tag_match;

    // victim is whatever sits in the selected set
    assign victim_dirty = frame.tag.valid && frame.tag.dirty;
    assign victim_addr  = {frame.tag.tag_bits, sel, {`L1_BLOCK_BITS{1'b0}}, 2'b00};

    assign rdata = frame.data[addr.word_idx];

    always_comb begin
        hit_frame           = frame;
        hit_frame.tag.dirty = 1'b1;
        hit_frame.data[addr.word_idx] = merge_word(frame.data[addr.word_idx], req.wdata,
                                                   req.byte_en);

        // new block from memory, write miss data folded in
        fill_frame.tag.valid    = 1'b1;
        fill_frame.tag.dirty    = req.wen;
        fill_frame.tag.tag_bits = addr.tag_bits;
        fill_frame.data         = fill;
        if (req.wen) begin
            fill_frame.data[addr.word_idx] = merge_word(fill[addr.word_idx], req.wdata,
                                                        req.byte_en);
        end
    end

endmodule

`default_nettype wire

// File: cache_controller.sv
// cache FSM, drives the memory bus, processor busy and frame RAM writes
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_controller (
    input  logic                    CLK,
    input  logic                    nRST,
    input  cache_pkg::cpu_req_t     req,
    input  logic                    flush,
    input  logic                    hit,
    input  logic                    victim_dirty,
    input  logic [`L1_ADDR_W-1:0]   victim_addr,
    input  cache_pkg::cache_frame_t frame,
    input  cache_pkg::cache_frame_t hit_frame,
    input  cache_pkg::cache_frame_t fill_frame,
    input  cache_pkg::mem_rsp_t     mem_rsp,
    output cache_pkg::mem_req_t     mem_req,
    output logic                    busy,
    output logic                    flush_done,
    output logic [`L1_SET_BITS-1:0] ram_sel,
    output logic                    ram_wen,
    output cache_pkg::cache_frame_t ram_wval,
    output cache_pkg::cache_frame_t ram_wmask,
    output cache_pkg::cache_state_t state
);
    import cache_pkg::*;

    cache_state_t            next_state;
    cache_addr_t             req_addr;
    logic [`L1_SET_BITS-1:0] set_cnt;
    logic [`L1_SET_BITS:0]   set_cnt_inc;    // top bit is the finish flag
    logic [`L1_SET_BITS-1:0] next_set_cnt;
    logic                    cnt_step;
    logic                    flush_req;
    logic                    next_flush_req;
    logic                    req_any;

    assign req_addr    = cache_addr_t'(req.addr);
    assign req_any     = req.ren || req.wen;
    assign set_cnt_inc = {1'b0, set_cnt} + 1'b1;

    // counter owns the RAM during clear and flush
    assign ram_sel = (state == CLEAR || state == FLUSH) ? set_cnt
                                                        : req_addr.set_idx;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= CLEAR;
            set_cnt   <= '0;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            set_cnt   <= next_set_cnt;
            flush_req <= next_flush_req;
        end
    end

    // strobe held until the flush is over
    assign next_flush_req = (flush_req || flush) && !flush_done;

    always_comb begin
        next_set_cnt = set_cnt;
        if (cnt_step) begin
            next_set_cnt = set_cnt_inc[`L1_SET_BITS-1:0];   // wraps to set 0
        end
    end

    always_comb begin
        next_state = state;
        cnt_step   = 1'b0;
        busy       = 1'b1;
        flush_done = 1'b0;
        ram_wen    = 1'b0;
        ram_wval   = '0;
        ram_wmask  = '0;    // full write unless narrowed below
        mem_req    = '0;

        case (state)
            CLEAR: begin
                ram_wen  = 1'b1;    // zero frame
                cnt_step = 1'b1;
                if (set_cnt_inc[`L1_SET_BITS]) begin
                    next_state = READY;
                end
            end
            READY: begin
                if (hit) begin
                    busy = 1'b0;
                    if (req.wen) begin
                        ram_wen  = 1'b1;
                        ram_wval = hit_frame;
                    end
                end else if (req_any) begin
                    next_state = victim_dirty ? WRITEBACK : FETCH;
                end else if (flush_req || flush) begin
                    next_state = FLUSH;
                end
            end
            WRITEBACK: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = victim_addr;
                mem_req.wdata = frame.data;
                if (!mem_rsp.busy) begin
                    // victim stays, only its dirty bit drops
                    ram_wen             = 1'b1;
                    ram_wval            = frame;
                    ram_wval.tag.dirty  = 1'b0;
                    ram_wmask           = '1;
                    ram_wmask.tag.dirty = 1'b0;
                    next_state          = READY;
                end
            end
            FETCH: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {req_addr.tag_bits, req_addr.set_idx,
                                {`L1_BLOCK_BITS{1'b0}}, 2'b00};
                if (!mem_rsp.busy) begin
                    ram_wen    = 1'b1;
                    ram_wval   = fill_frame;
                    next_state = READY;
                end
            end
            FLUSH: begin
                if (victim_dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = victim_addr;
                    mem_req.wdata = frame.data;
                end
                // clean sets move on at once
                if (!victim_dirty || !mem_rsp.busy) begin
                    ram_wen  = 1'b1;
                    cnt_step = 1'b1;
                    if (set_cnt_inc[`L1_SET_BITS]) begin
                        flush_done = 1'b1;
                        next_state = READY;
                    end
                end
            end
            default: begin
                next_state = CLEAR;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: l1_cache.sv
// top of the direct-mapped write-back L1 data cache, between the processor bus and memory
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module l1_cache (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp,
    input  logic                flush,
    output logic                flush_done
);
    import cache_pkg::*;

    cache_state_t            state;
    cache_frame_t            frame;
    cache_frame_t            hit_frame;
    cache_frame_t            fill_frame;
    cache_frame_t            ram_wval;
    cache_frame_t            ram_wmask;
    logic [`L1_SET_BITS-1:0] ram_sel;
    logic                    ram_wen;
    logic                    hit;
    logic                    victim_dirty;
    logic [`L1_ADDR_W-1:0]   victim_addr;

    cache_frame_ram i_ram (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (ram_sel),
        .wen   (ram_wen),
        .wval  (ram_wval),
        .wmask (ram_wmask),
        .rval  (frame)
    );

    cache_lookup i_lookup (
        .state        (state),
        .req          (cpu_req),
        .sel          (ram_sel),
        .frame        (frame),
        .fill         (mem_rsp.rdata),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .rdata        (cpu_rsp.rdata),
        .hit_frame    (hit_frame),
        .fill_frame   (fill_frame),
        .victim_addr  (victim_addr)
    );

    cache_controller i_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .req          (cpu_req),
        .flush        (flush),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .frame        (frame),
        .hit_frame    (hit_frame),
        .fill_frame   (fill_frame),
        .mem_rsp      (mem_rsp),
        .mem_req      (mem_req),
        .busy         (cpu_rsp.busy),
        .flush_done   (flush_done),
        .ram_sel      (ram_sel),
        .ram_wen      (ram_wen),
        .ram_wval     (ram_wval),
        .ram_wmask    (ram_wmask),
        .state        (state)
    );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
// behavioral block memory on the cache's memory bus, random wait states, counts block transfers
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_mem_model #(
    parameter logic [`L1_WORD_W-1:0] FILL_KEY = 32'h0
) (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::mem_req_t req,
    output cache_pkg::mem_rsp_t rsp,
    output int                  read_cnt,
    output int                  write_cnt
);
    import cache_pkg::*;

    localparam int IDX_W = 12;
    localparam int DEPTH = 1 << IDX_W;

    word_t             mem [DEPTH];
    logic              active;      // transfer accepted, counting down
    logic [1:0]        wait_cnt;
    logic [IDX_W-1:0]  base;

    assign base = req.addr[IDX_W+1:2];   // word index of the block start

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = word_t'(i << 2) ^ FILL_KEY;
        end
    end

    always_comb begin
        rsp.busy = !(active && wait_cnt == 2'd0);
        for (int w = 0; w < `L1_BLOCK_WORDS; w++) begin
            rsp.rdata[w] = mem[base + w];
        end
    end

    // first cycle of a request is always busy, then 0 to 3 more
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            active    <= 1'b0;
            wait_cnt  <= 2'd0;
            read_cnt  <= 0;
            write_cnt <= 0;
        end else if (req.ren || req.wen) begin
            if (!active) begin
                active   <= 1'b1;
                wait_cnt <= 2'($urandom % 4);
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                active <= 1'b0;   // completes at this edge
                if (req.wen) begin
                    for (int w = 0; w < `L1_BLOCK_WORDS; w++) begin
                        mem[base + w] <= req.wdata[w];
                    end
                    write_cnt <= write_cnt + 1;
                end else begin
                    read_cnt <= read_cnt + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: l1_cache_assertions.sv
// protocol assertions on the cache's memory bus, flush pulse and clear phase, bound into l1_cache
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module l1_cache_assertions (
    input logic                CLK,
    input logic                nRST,
    input cache_pkg::cpu_rsp_t cpu_rsp,
    input cache_pkg::mem_req_t mem_req,
    input cache_pkg::mem_rsp_t mem_rsp,
    input logic                flush_done
);
    int fail_cnt = 0;       // read by the testbench
    int clear_cycles;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            clear_cycles <= 0;
        end else if (clear_cycles < `L1_N_SETS) begin
            clear_cycles <= clear_cycles + 1;
        end
    end

    a_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin fail_cnt++; $error("memory read and write requested together"); end

    a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) && mem_rsp.busy |=> $stable(mem_req))
        else begin fail_cnt++; $error("memory request changed while busy"); end

    a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else begin fail_cnt++; $error("flush_done longer than one cycle"); end

    a_clear_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (clear_cycles < `L1_N_SETS) |-> cpu_rsp.busy)
        else begin fail_cnt++; $error("processor busy low during clear"); end

endmodule

bind l1_cache l1_cache_assertions i_checks (
    .CLK        (CLK),
    .nRST       (nRST),
    .cpu_rsp    (cpu_rsp),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .flush_done (flush_done)
);

`default_nettype wire

// File: tb_l1_cache.sv
// testbench for the L1 data cache, seeded random traffic checked against a flat reference memory
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_l1_cache;
    import cache_pkg::*;

    typedef logic [`L1_ADDR_W-1:0] addr_t;

    localparam int    N_TRANS    = 400;
    localparam int    MAX_CYCLES = N_TRANS * 20 + 2000;
    localparam int    DEPTH      = 4096;          // same span as the memory model
    localparam word_t FILL_KEY   = 32'h5a3c_96e1;

    logic     CLK;
    logic     nRST;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     flush;
    logic     flush_done;
    int       mem_reads;
    int       mem_writes;

    word_t ref_mem [DEPTH];
    logic  touched [DEPTH];
    int    cycle_cnt = 0;
    int    value_errs = 0;
    int    other_errs = 0;

    l1_cache i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush      (flush),
        .flush_done (flush_done)
    );

    tb_mem_model #(.FILL_KEY(FILL_KEY)) i_mem (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (mem_req),
        .rsp       (mem_rsp),
        .read_cnt  (mem_reads),
        .write_cnt (mem_writes)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a request or flush never finished", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int word_idx(input addr_t addr);
        return int'(addr[13:2]);
    endfunction

    // slot picks one of 4 tags, w covers the block word and sets 0 to 7
    function automatic addr_t make_addr(input int slot, input int w);
        return (addr_t'(slot) << 12) | (addr_t'(w) << 2);
    endfunction

    function automatic addr_t pick_addr();
        int slot;
        int w;
        slot = $urandom % 4;
        w    = $urandom % 16;
        return make_addr(slot, w);
    endfunction

    // one processor access, held until busy is low, then checked or applied to the model
    task automatic access(input string name, input logic is_write, input addr_t addr,
                          input word_t wdata, input logic [3:0] be, output int cycles);
        word_t expected;
        int    idx;
        logic  done;
        idx             = word_idx(addr);
        cpu_req.ren     = !is_write;
        cpu_req.wen     = is_write;
        cpu_req.addr    = addr;
        cpu_req.wdata   = wdata;
        cpu_req.byte_en = be;
        cycles          = 0;
        done            = 1'b0;
        while (!done) begin
            @(posedge CLK);
            cycles++;
            done = !cpu_rsp.busy;
        end
        if (is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
            end
        end else begin
            expected = ref_mem[idx];
            if (cpu_rsp.rdata !== expected) begin
                $display("FAILED %s: expected %h, actual %h", name, expected, cpu_rsp.rdata);
                value_errs++;
            end
        end
        touched[idx] = 1'b1;
        @(negedge CLK);
        cpu_req = '0;
    endtask

    initial begin
        int    seed_val;
        int    cycles;
        int    reads_before;
        int    writes_before;
        int    total;
        logic  done_seen;
        addr_t a;
        addr_t b;
        seed_val = $urandom(94);
        cpu_req  = '0;
        flush    = 1'b0;
        nRST     = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i] = word_t'(i << 2) ^ FILL_KEY;
            touched[i] = 1'b0;
        end
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        // clear phase has to finish before anything completes
        a = make_addr(2, 5);
        access("reset_read", 1'b0, a, '0, 4'h0, cycles);
        if (cycles <= `L1_N_SETS) begin
            $display("first request completed %0d cycles after reset, inside the clear", cycles);
            other_errs++;
        end

        reads_before = mem_reads;
        access("hit_read", 1'b0, a, '0, 4'h0, cycles);
        if (mem_reads != reads_before) begin
            $display("second read of a cached address went to memory");
            other_errs++;
        end

        // same set, other tag, so the dirty frame has to go back
        a = make_addr(0, 6);
        b = make_addr(3, 6);
        access("conflict_write", 1'b1, a, $urandom, 4'hf, cycles);
        writes_before = mem_writes;
        access("conflict_read", 1'b0, b, '0, 4'h0, cycles);
        if (mem_writes != writes_before + 1) begin
            $display("dirty victim was not written back exactly once on the conflict");
            other_errs++;
        end
        if (i_mem.mem[word_idx(a)] !== ref_mem[word_idx(a)]) begin
            $display("FAILED writeback_check: expected %h, actual %h",
                     ref_mem[word_idx(a)], i_mem.mem[word_idx(a)]);
            value_errs++;
        end

        for (int n = 0; n < N_TRANS; n++) begin
            a = pick_addr();
            if ($urandom % 2) begin
                access("random_write", 1'b1, a, $urandom, 4'(($urandom % 15) + 1), cycles);
            end else begin
                access("random_read", 1'b0, a, '0, 4'h0, cycles);
            end
        end

        flush = 1'b1;   // one-cycle strobe
        @(negedge CLK);
        flush     = 1'b0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge CLK);
            done_seen = flush_done;
        end
        @(negedge CLK);
        for (int i = 0; i < DEPTH; i++) begin
            if (touched[i] && i_mem.mem[i] !== ref_mem[i]) begin
                $display("FAILED flush_writeback word %0d: expected %h, actual %h",
                         i, ref_mem[i], i_mem.mem[i]);
                value_errs++;
            end
        end

        // a was cached by the last random access, flush emptied it
        reads_before = mem_reads;
        access("post_flush_read", 1'b0, a, '0, 4'h0, cycles);
        if (mem_reads == reads_before) begin
            $display("read after the flush was served without a memory fetch");
            other_errs++;
        end

        total = value_errs + other_errs + i_dut.i_checks.fail_cnt;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errs, other_errs, i_dut.i_checks.fail_cnt);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
cache_pkg.sv
cache_frame_ram.sv
cache_lookup.sv
cache_controller.sv
l1_cache.sv
tb_mem_model.sv
l1_cache_assertions.sv
tb_l1_cache.sv

// File: Bender.yml
package:
  name: l1_cache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - cache_frame_ram.sv
      - cache_lookup.sv
      - cache_controller.sv
      - l1_cache.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_mem_model.sv
      - l1_cache_assertions.sv
      - tb_l1_cache.sv
